// ==== list.f ====
fifo_pkg.sv
key_writer.sv
fifo_buffer.sv
seg_reader.sv
fifo_top.sv
fifo_checker.sv
fifo_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fifo_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fifo_tb.sv ====
// Testbench for the hex-digit queue
// Table of key presses checked against a reference queue and segment table
`default_nettype none

module fifo_tb import fifo_pkg::*; ();

  localparam int ADDR_W   = 4;
  localparam int CAPACITY = 2 ** ADDR_W - 1;

  // Lit segments per digit, active high, bit order g..a
  localparam logic [6:0] LIT [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
  };

  typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RD, OP_BOTH} op_t;

  // Stimulus and expected flags for one press
  typedef struct packed {
    op_t   op;
    data_t data;
    logic  full;
    logic  empty;
    logic  new_disp;
  } row_t;

  logic  div;
  logic  rst;
  logic  wr;
  logic  rd;
  data_t datain;
  seg_t  led_n;
  logic  full;
  logic  empty;

  row_t  rows[$];
  string names[$];
  // Reference queue and the handshakes it still owes
  data_t model_q[$];
  logic  wr_held;
  data_t held_val;
  logic  rd_waiting;
  seg_t  exp_disp;
  int    cycles = 0;
  int    limit;

  fifo_top #(
    .ADDR_W (ADDR_W)
  ) uut (
    .div    (div),
    .rst    (rst),
    .wr     (wr),
    .rd     (rd),
    .datain (datain),
    .led_n  (led_n),
    .full   (full),
    .empty  (empty)
  );

  always #5 div = ~div;

  always @(posedge div) begin
    cycles <= cycles + 1;
    if (cycles >= limit)
      abort_run("Timeout, the run went past its cycle limit");
  end

  task automatic mismatch(input string name, input string what, input int exp, input int act);
    $display("FAIL %s: %s expected %0h, actual %0h", name, what, exp, act);
    $display("Test failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic add_row(input string name, input op_t op, input data_t d,
                         input logic f, input logic e, input logic nd);
    row_t r;
    r = '{op, d, f, e, nd};
    rows.push_back(r);
    names.push_back(name);
  endtask

  function automatic seg_t seg_of(input data_t v);
    return ~LIT[v];
  endfunction

  task automatic model_write(input data_t v);
    // A press during a held write is lost
    if (!wr_held) begin
      if (model_q.size() < CAPACITY)
        model_q.push_back(v);
      else begin
        wr_held  = 1'b1;
        held_val = v;
      end
    end
    // A read parked on empty takes the new value at once
    if (rd_waiting && model_q.size() > 0) begin
      exp_disp   = seg_of(model_q.pop_front());
      rd_waiting = 1'b0;
    end
  endtask

  task automatic model_read();
    if (!rd_waiting) begin
      if (model_q.size() > 0) begin
        exp_disp = seg_of(model_q.pop_front());
        // Freed slot goes to the held write
        if (wr_held) begin
          model_q.push_back(held_val);
          wr_held = 1'b0;
        end
      end else
        rd_waiting = 1'b1;
    end
  endtask

  task automatic build_table();
    // Order and display
    add_row("order_wr_5", OP_WR, 4'h5, 1'b0, 1'b0, 1'b0);
    add_row("order_wr_a", OP_WR, 4'ha, 1'b0, 1'b0, 1'b0);
    add_row("order_wr_7", OP_WR, 4'h7, 1'b0, 1'b0, 1'b0);
    add_row("order_idle", OP_IDLE, 4'h0, 1'b0, 1'b0, 1'b0);
    add_row("order_rd_5", OP_RD, 4'h0, 1'b0, 1'b0, 1'b1);
    add_row("order_rd_a", OP_RD, 4'h0, 1'b0, 1'b0, 1'b1);
    add_row("order_rd_7", OP_RD, 4'h0, 1'b0, 1'b1, 1'b1);
    // Read parks on empty until a write arrives
    add_row("empty_rd", OP_RD, 4'h0, 1'b0, 1'b1, 1'b0);
    add_row("empty_wr_9", OP_WR, 4'h9, 1'b0, 1'b1, 1'b1);
    // Simultaneous presses on a partly filled buffer
    add_row("both_wr_2", OP_WR, 4'h2, 1'b0, 1'b0, 1'b0);
    add_row("both_wr_c", OP_WR, 4'hc, 1'b0, 1'b0, 1'b0);
    add_row("both_wr4_rd2", OP_BOTH, 4'h4, 1'b0, 1'b0, 1'b1);
    add_row("both_rd_c", OP_RD, 4'h0, 1'b0, 1'b0, 1'b1);
    add_row("both_rd_4", OP_RD, 4'h0, 1'b0, 1'b1, 1'b1);
    // Fill with 1..F, then one write held by back-pressure
    for (int i = 1; i <= CAPACITY; i++)
      add_row($sformatf("fill_wr_%0h", i), OP_WR, data_t'(i), i == CAPACITY, 1'b0, 1'b0);
    add_row("full_wr_0_held", OP_WR, 4'h0, 1'b1, 1'b0, 1'b0);
    add_row("full_rd_frees", OP_RD, 4'h0, 1'b1, 1'b0, 1'b1);
    // Drain until the held 0 comes out last
    for (int i = 0; i < CAPACITY; i++)
      add_row($sformatf("drain_rd_%0d", i), OP_RD, 4'h0, 1'b0, i == CAPACITY - 1, 1'b1);
  endtask

  initial begin
    row_t r;
    seg_t prev;
    div        = 1'b0;
    rst        = 1'b0;
    wr         = 1'b1;
    rd         = 1'b1;
    datain     = '0;
    wr_held    = 1'b0;
    held_val   = '0;
    rd_waiting = 1'b0;
    exp_disp   = 7'h7f;
    build_table();
    // Reset, ten cycles per row and some slack
    limit = rows.size() * 10 + 50;
    repeat (5) @(negedge div);
    rst = 1'b1;
    assert (led_n == 7'h7f) else mismatch("reset", "led_n", 32'h7f, int'(led_n));
    assert (!full && empty) else mismatch("reset", "full,empty", 1, int'({full, empty}));
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      // One-cycle press
      @(negedge div);
      datain = r.data;
      wr     = !(r.op inside {OP_WR, OP_BOTH});
      rd     = !(r.op inside {OP_RD, OP_BOTH});
      @(negedge div);
      wr = 1'b1;
      rd = 1'b1;
      // Covers a handshake released by a back-pressured partner too
      repeat (8) @(negedge div);
      prev = exp_disp;
      if (r.op inside {OP_WR, OP_BOTH})
        model_write(r.data);
      if (r.op inside {OP_RD, OP_BOTH})
        model_read();
      assert (full == r.full) else mismatch(names[i], "full", int'(r.full), int'(full));
      assert (empty == r.empty) else mismatch(names[i], "empty", int'(r.empty), int'(empty));
      assert (led_n == (r.new_disp ? exp_disp : prev))
        else mismatch(names[i], "led_n", int'(r.new_disp ? exp_disp : prev), int'(led_n));
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fifo_checker.sv ====
// Assertion checker for the circular hex-digit buffer
// Bound into fifo_buffer, watches pointers, flags and both handshakes
`default_nettype none

module fifo_checker import fifo_pkg::*; #(
  parameter int ADDR_W = 4
) (
  input logic              div,
  input logic              rst,
  input wr_req_t           wr_req,
  input logic              wr_ack,
  input logic              rd_req,
  input rd_rsp_t           rd_rsp,
  input logic              full,
  input logic              empty,
  input logic [ADDR_W-1:0] wr_ptr,
  input logic [ADDR_W-1:0] rd_ptr
);

  typedef logic [ADDR_W-1:0] ptr_t;

  // Entries held, counted modulo the memory size
  ptr_t used;

  assign used = wr_ptr - rd_ptr;

  // One cycle into reset the buffer is idle and empty
  reset_state: assert property (@(posedge div)
    !rst |=> (wr_ptr == '0 && rd_ptr == '0 && !full && empty && !wr_ack && !rd_rsp.ack))
    else $error("buffer not idle after reset");

  // Pointers step by one as their ack rises and hold otherwise
  wr_ptr_step: assert property (@(posedge div) disable iff (!rst)
    wr_ptr == ((wr_ack && !$past(wr_ack)) ?
               $past(wr_ptr) + ptr_t'(1) : $past(wr_ptr)))
    else $error("write pointer moved without an accepted write");
  rd_ptr_step: assert property (@(posedge div) disable iff (!rst)
    rd_ptr == ((rd_rsp.ack && !$past(rd_rsp.ack)) ?
               $past(rd_ptr) + ptr_t'(1) : $past(rd_ptr)))
    else $error("read pointer moved without an accepted read");

  flags_apart: assert property (@(posedge div) disable iff (!rst) !(full && empty))
    else $error("full and empty both high");

  // One slot stays unused, so full is one entry below the memory size
  flags_match: assert property (@(posedge div) disable iff (!rst)
    full == (used == '1) && empty == (used == '0))
    else $error("flags do not match the pointer difference");

  no_ack_full: assert property (@(posedge div) disable iff (!rst)
    full && !wr_ack |=> !wr_ack)
    else $error("write ack rose while full");

  // Ack drops only after its req has dropped
  wr_ack_hold: assert property (@(posedge div) disable iff (!rst)
    wr_ack && wr_req.req |=> wr_ack)
    else $error("write ack fell before write req");
  rd_ack_hold: assert property (@(posedge div) disable iff (!rst)
    rd_rsp.ack && rd_req |=> rd_rsp.ack)
    else $error("read ack fell before read req");

endmodule

bind fifo_buffer fifo_checker #(
  .ADDR_W (ADDR_W)
) u_fifo_checker (
  .div    (div),
  .rst    (rst),
  .wr_req (wr_req),
  .wr_ack (wr_ack),
  .rd_req (rd_req),
  .rd_rsp (rd_rsp),
  .full   (full),
  .empty  (empty),
  .wr_ptr (wr_ptr),
  .rd_ptr (rd_ptr)
);

`default_nettype wire

// ==== fifo_top.sv ====
// Hex-digit queue top level
// Write key and switches feed the producer, the buffer holds up to
// 2**ADDR_W - 1 digits, the read key pops one onto the display
`default_nettype none

module fifo_top import fifo_pkg::*; #(
  parameter int ADDR_W = 4
) (
  input  logic  div,
  input  logic  rst,
  input  logic  wr,
  input  logic  rd,
  input  data_t datain,
  output seg_t  led_n,
  output logic  full,
  output logic  empty
);

  // Write side handshake
  wr_req_t wr_req;
  logic    wr_ack;
  // Read side handshake
  logic    rd_req;
  rd_rsp_t rd_rsp;

  key_writer u_key_writer (
    .div    (div),
    .rst    (rst),
    .wr     (wr),
    .datain (datain),
    .wr_req (wr_req),
    .wr_ack (wr_ack)
  );

  fifo_buffer #(
    .ADDR_W (ADDR_W)
  ) u_fifo_buffer (
    .div    (div),
    .rst    (rst),
    .wr_req (wr_req),
    .wr_ack (wr_ack),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .full   (full),
    .empty  (empty)
  );

  seg_reader u_seg_reader (
    .div    (div),
    .rst    (rst),
    .rd     (rd),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .led_n  (led_n)
  );

endmodule

`default_nettype wire

// ==== seg_reader.sv ====
// Read-key consumer and display driver
// Turns one press of the active-low read key into a four-phase pop
// and shows the returned digit on an active-low seven-segment digit
`default_nettype none

module seg_reader import fifo_pkg::*; (
  input  logic    div,
  input  logic    rst,
  input  logic    rd,
  output logic    rd_req,
  input  rd_rsp_t rd_rsp,
  output seg_t    led_n
);

  logic       key_s;
  logic       key_q;
  logic       press;
  key_state_t state;

  // Hex digit to active-low pattern, bit order g..a
  function automatic seg_t hex_to_seg(input data_t v);
    seg_t s;
    case (v)
      4'h0: s = 7'b1000000;
      4'h1: s = 7'b1111001;
      4'h2: s = 7'b0100100;
      4'h3: s = 7'b0110000;
      4'h4: s = 7'b0011001;
      4'h5: s = 7'b0010010;
      4'h6: s = 7'b0000010;
      4'h7: s = 7'b1111000;
      4'h8: s = 7'b0000000;
      4'h9: s = 7'b0010000;
      // Letters A b C d E F
      4'ha: s = 7'b0001000;
      4'hb: s = 7'b0000011;
      4'hc: s = 7'b1000110;
      4'hd: s = 7'b0100001;
      4'he: s = 7'b0000110;
      default: s = 7'b0001110;
    endcase
    return s;
  endfunction

  assign press = key_q && !key_s;

  // Same two-stage key sampling as the write side
  always_ff @(posedge div) begin
    if (!rst) begin
      key_s <= 1'b1;
      key_q <= 1'b1;
    end else begin
      key_s <= rd;
      key_q <= key_s;
    end
  end

  always_ff @(posedge div) begin
    if (!rst) begin
      state  <= IDLE;
      rd_req <= 1'b0;
      // Blank digit
      led_n  <= 7'b1111111;
    end else begin
      case (state)
        IDLE: begin
          if (press) begin
            rd_req <= 1'b1;
            state  <= REQ;
          end
        end
        REQ: begin
          // Waits here for as long as the buffer is empty
          if (rd_rsp.ack) begin
            rd_req <= 1'b0;
            led_n  <= hex_to_seg(rd_rsp.data);
            state  <= REL;
          end
        end
        REL: begin
          if (!rd_rsp.ack)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== fifo_buffer.sv ====
// Circular hex-digit buffer
// Memory of 2**ADDR_W entries holding one fewer, so full and empty
// stay apart. Two four-phase slave ports, one for writes and one
// for reads, plus registered full and empty flags
`default_nettype none

module fifo_buffer import fifo_pkg::*; #(
  parameter int ADDR_W = 4
) (
  input  logic    div,
  input  logic    rst,
  input  wr_req_t wr_req,
  output logic    wr_ack,
  input  logic    rd_req,
  output rd_rsp_t rd_rsp,
  output logic    full,
  output logic    empty
);

  localparam int DEPTH = 2 ** ADDR_W;

  typedef logic [ADDR_W-1:0] ptr_t;

  data_t mem [DEPTH];

  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  ptr_t  wr_ptr_nxt;
  ptr_t  rd_ptr_nxt;
  logic  wr_fire;
  logic  rd_fire;
  logic  rd_ack;
  data_t rd_data;

  // New request only while the previous ack has dropped
  // Writes wait for a free slot, reads for a stored entry
  assign wr_fire = wr_req.req && !wr_ack && !full;
  assign rd_fire = rd_req && !rd_ack && !empty;

  // Pointers wrap by plain overflow of ADDR_W bits
  assign wr_ptr_nxt = wr_fire ? wr_ptr + ptr_t'(1) : wr_ptr;
  assign rd_ptr_nxt = rd_fire ? rd_ptr + ptr_t'(1) : rd_ptr;

  always_ff @(posedge div) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      wr_ptr <= wr_ptr_nxt;
      rd_ptr <= rd_ptr_nxt;
      // Flags from the next pointers, so they move with the accept
      // Both accepts together leave the difference and the flags alone
      full   <= (wr_ptr_nxt + ptr_t'(1)) == rd_ptr_nxt;
      empty  <= wr_ptr_nxt == rd_ptr_nxt;
    end
  end

  // Write port handshake
  always_ff @(posedge div) begin
    if (!rst) begin
      wr_ack <= 1'b0;
    end else if (wr_fire) begin
      wr_ack <= 1'b1;
    end else if (!wr_req.req) begin
      // Ack only drops after the producer has let go
      wr_ack <= 1'b0;
    end
  end

  // Read port handshake
  always_ff @(posedge div) begin
    if (!rst) begin
      rd_ack <= 1'b0;
    end else if (rd_fire) begin
      rd_ack <= 1'b1;
    end else if (!rd_req) begin
      rd_ack <= 1'b0;
    end
  end

  // Storage and read data path
  always_ff @(posedge div) begin
    if (wr_fire)
      mem[wr_ptr] <= wr_req.data;
    // Oldest entry, held until the next accepted read
    if (rd_fire)
      rd_data <= mem[rd_ptr];
  end

  assign rd_rsp.ack  = rd_ack;
  assign rd_rsp.data = rd_data;

endmodule

`default_nettype wire

// ==== key_writer.sv ====
// Write-key producer
// Turns one press of the active-low write key into a single
// four-phase write request carrying the switch value
`default_nettype none

module key_writer import fifo_pkg::*; (
  input  logic    div,
  input  logic    rst,
  input  logic    wr,
  input  data_t   datain,
  output wr_req_t wr_req,
  input  logic    wr_ack
);

  // Key sample and the sample before it
  logic       key_s;
  logic       key_q;
  logic       press;
  key_state_t state;
  logic       req;
  // Value held for the duration of the handshake
  data_t      data_q;

  // High for one cycle after the key goes from high to low
  assign press = key_q && !key_s;

  always_ff @(posedge div) begin
    if (!rst) begin
      // Key idles high, so a key held at reset is not a press
      key_s <= 1'b1;
      key_q <= 1'b1;
    end else begin
      key_s <= wr;
      key_q <= key_s;
    end
  end

  always_ff @(posedge div) begin
    if (!rst) begin
      state <= IDLE;
      req   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Presses during REQ or REL fall through and are lost
          if (press) begin
            req   <= 1'b1;
            state <= REQ;
          end
        end
        REQ: begin
          // Stays here while the buffer is full
          if (wr_ack) begin
            req   <= 1'b0;
            state <= REL;
          end
        end
        REL: begin
          if (!wr_ack)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Switch value captured on the press
  always_ff @(posedge div) begin
    if (state == IDLE && press)
      data_q <= datain;
  end

  assign wr_req.req  = req;
  assign wr_req.data = data_q;

endmodule

`default_nettype wire

// ==== fifo_pkg.sv ====
// Hex-digit queue shared types
// Data and segment widths, handshake structs and the
// state encoding used by the key-driven producer and consumer
`default_nettype none

package fifo_pkg;

  // One hex digit as stored in the queue and shown on the display
  typedef logic [3:0] data_t;

  // Active-low segment pattern
  // Bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg_t;

  // Write side of the queue, producer to buffer
  // Data must stay stable while req is high
  typedef struct packed {
    logic  req;
    data_t data;
  } wr_req_t;

  // Read side of the queue, buffer to consumer
  // Data is valid for as long as ack is high
  typedef struct packed {
    logic  ack;
    data_t data;
  } rd_rsp_t;

  // Four-phase requester state
  // IDLE  waiting for a key press
  // REQ   request high, waiting for ack
  // REL   request low, waiting for ack to fall
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    REL  = 2'd2
  } key_state_t;

endpackage

`default_nettype wire
